//--- logic/fpu_pkg.sv
package fpu_pkg;

  // Elements are 16-bit two's complement fixed point
  localparam int DATA_W = 16;

  typedef logic signed [DATA_W-1:0] elem_t;

  // Saturation limits
  localparam elem_t ELEM_MAX = {1'b0, {(DATA_W-1){1'b1}}};
  localparam elem_t ELEM_MIN = {1'b1, {(DATA_W-1){1'b0}}};

  typedef enum logic [1:0] {
    OP_RELU_FW      = 2'd0,
    OP_RELU_BW      = 2'd1,
    OP_PARAM_UPDATE = 2'd2,
    OP_MSE_BW       = 2'd3
  } op_e;

  // Element count of one job
  localparam int LEN_W = 8;

  typedef logic [LEN_W-1:0] len_t;

endpackage

//--- logic/mem_pkg.sv
package mem_pkg;

  // Word address into the vector memory
  localparam int ADDR_W = 10;

  typedef logic [ADDR_W-1:0] addr_t;

endpackage

//--- logic/elementwise_alu.sv
`timescale 1ns/1ps

module elementwise_alu #(
  parameter int LR_SHIFT = 3
) (
  input  fpu_pkg::op_e   op,
  input  fpu_pkg::elem_t opnd_a,
  input  fpu_pkg::elem_t opnd_b,
  output fpu_pkg::elem_t result
);

  // One guard bit above the element width
  logic [fpu_pkg::DATA_W:0] diff_wide;
  fpu_pkg::elem_t           subtrahend;
  fpu_pkg::elem_t           diff_sat;
  logic                     a_pos;

  // Only strictly positive values count as active
  assign a_pos = !opnd_a[fpu_pkg::DATA_W-1] && (opnd_a != '0);

  // Gradient scaled by the learning rate with its sign kept
  assign subtrahend = (op == fpu_pkg::OP_PARAM_UPDATE) ? (opnd_b >>> LR_SHIFT) : opnd_b;

  assign diff_wide = {opnd_a[fpu_pkg::DATA_W-1], opnd_a} -
                     {subtrahend[fpu_pkg::DATA_W-1], subtrahend};

  // Top two bits disagree on overflow
  always_comb begin
    if (diff_wide[fpu_pkg::DATA_W] == diff_wide[fpu_pkg::DATA_W-1]) begin
      diff_sat = fpu_pkg::elem_t'(diff_wide[fpu_pkg::DATA_W-1:0]);
    end else if (diff_wide[fpu_pkg::DATA_W]) begin
      diff_sat = fpu_pkg::ELEM_MIN;
    end else begin
      diff_sat = fpu_pkg::ELEM_MAX;
    end
  end

  always_comb begin
    unique case (op)
      fpu_pkg::OP_RELU_FW: begin
        result = a_pos ? opnd_a : '0;
      end
      fpu_pkg::OP_RELU_BW: begin
        // Gradient passes only where the forward input was active
        result = a_pos ? opnd_b : '0;
      end
      fpu_pkg::OP_PARAM_UPDATE: begin
        result = diff_sat;
      end
      fpu_pkg::OP_MSE_BW: begin
        result = diff_sat;
      end
      default: begin
        result = '0;
      end
    endcase
  end

  always_comb begin
    assert final (!$isunknown(op))
      else $error("elementwise_alu: opcode is unknown");
  end

endmodule

//--- logic/job_sequencer.sv
`timescale 1ns/1ps

module job_sequencer (
  input  logic           clk,
  input  logic           rst_l,

  // Job request
  input  logic           start,
  input  fpu_pkg::op_e   op,
  input  mem_pkg::addr_t src_a,
  input  mem_pkg::addr_t src_b,
  input  mem_pkg::addr_t dst,
  input  fpu_pkg::len_t  len,

  // Job status
  output logic           busy,
  output logic           done,
  output logic [3:0]     job_count,

  // Memory port
  output logic           rd_en,
  output mem_pkg::addr_t rd_addr,
  input  fpu_pkg::elem_t rd_data,
  output logic           wr_en,
  output mem_pkg::addr_t wr_addr,
  output fpu_pkg::elem_t wr_data,

  // ALU side
  output fpu_pkg::op_e   alu_op,
  output fpu_pkg::elem_t opnd_a,
  output fpu_pkg::elem_t opnd_b,
  input  fpu_pkg::elem_t result
);

  typedef enum logic [2:0] {
    IDLE,
    READ_A,
    READ_B,
    WRITE,
    FINISH
  } state_e;

  state_e state;
  state_e next_state;

  // Latched job descriptor
  fpu_pkg::op_e   op_q;
  mem_pkg::addr_t src_a_q;
  mem_pkg::addr_t src_b_q;
  mem_pkg::addr_t dst_q;
  fpu_pkg::len_t  len_q;

  fpu_pkg::len_t  idx;
  mem_pkg::addr_t offset;
  fpu_pkg::elem_t opnd_a_q;
  logic           accept;
  logic           last_elem;

  // Requests seen while busy are dropped
  assign accept = start && (state == IDLE);

  assign last_elem = ((idx + fpu_pkg::len_t'(1)) == len_q);
  assign offset = mem_pkg::addr_t'(idx);

  always_comb begin
    next_state = state;
    unique case (state)
      IDLE: begin
        if (accept) begin
          // Empty job goes straight to done
          next_state = (len == '0) ? FINISH : READ_A;
        end
      end
      READ_A: begin
        next_state = READ_B;
      end
      READ_B: begin
        next_state = WRITE;
      end
      WRITE: begin
        next_state = last_elem ? FINISH : READ_A;
      end
      FINISH: begin
        next_state = IDLE;
      end
      default: begin
        next_state = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_l) begin
    if (!rst_l) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  // Opcode of the job in flight
  always_ff @(posedge clk or negedge rst_l) begin
    if (!rst_l) begin
      op_q <= fpu_pkg::OP_RELU_FW;
    end else if (accept) begin
      op_q <= op;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      src_a_q <= src_a;
      src_b_q <= src_b;
      dst_q   <= dst;
      len_q   <= len;
    end
  end

  // Element index, advanced once per written element
  always_ff @(posedge clk or negedge rst_l) begin
    if (!rst_l) begin
      idx <= '0;
    end else if (accept) begin
      idx <= '0;
    end else if (state == WRITE) begin
      idx <= idx + fpu_pkg::len_t'(1);
    end
  end

  // First operand arrives the cycle after its read
  always_ff @(posedge clk) begin
    if (state == READ_B) begin
      opnd_a_q <= rd_data;
    end
  end

  always_ff @(posedge clk or negedge rst_l) begin
    if (!rst_l) begin
      job_count <= '0;
    end else if (state == FINISH) begin
      job_count <= job_count + 4'd1;
    end
  end

  assign busy = (state != IDLE);
  assign done = (state == FINISH);

  assign rd_en   = (state == READ_A) || (state == READ_B);
  assign rd_addr = (state == READ_B) ? (src_b_q + offset) : (src_a_q + offset);

  // Second operand is taken straight off the read data in WRITE
  assign wr_en   = (state == WRITE);
  assign wr_addr = dst_q + offset;
  assign wr_data = result;

  assign alu_op = op_q;
  assign opnd_a = opnd_a_q;
  assign opnd_b = rd_data;

  a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_l)
    !(rd_en && wr_en))
    else $error("job_sequencer: read and write in the same cycle");

  a_op_held: assert property (@(posedge clk) disable iff (!rst_l)
    (start && busy) |=> $stable(alu_op))
    else $error("job_sequencer: start while busy changed the opcode");

endmodule

//--- logic/fpu_job_manager.sv
`timescale 1ns/1ps

module fpu_job_manager #(
  parameter int LR_SHIFT = 3
) (
  input  logic           clk,
  input  logic           rst_l,

  // Job request and status
  input  logic           start,
  input  fpu_pkg::op_e   op,
  input  mem_pkg::addr_t src_a,
  input  mem_pkg::addr_t src_b,
  input  mem_pkg::addr_t dst,
  input  fpu_pkg::len_t  len,
  output logic           busy,
  output logic           done,
  output logic [3:0]     job_count,

  // External memory port
  output logic           rd_en,
  output mem_pkg::addr_t rd_addr,
  input  fpu_pkg::elem_t rd_data,
  output logic           wr_en,
  output mem_pkg::addr_t wr_addr,
  output fpu_pkg::elem_t wr_data
);

  fpu_pkg::op_e   alu_op;
  fpu_pkg::elem_t opnd_a;
  fpu_pkg::elem_t opnd_b;
  fpu_pkg::elem_t result;

  job_sequencer job_sequencer_i (
    .clk       (clk),
    .rst_l     (rst_l),
    .start     (start),
    .op        (op),
    .src_a     (src_a),
    .src_b     (src_b),
    .dst       (dst),
    .len       (len),
    .busy      (busy),
    .done      (done),
    .job_count (job_count),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .alu_op    (alu_op),
    .opnd_a    (opnd_a),
    .opnd_b    (opnd_b),
    .result    (result)
  );

  // Purely combinational so the result is written in the same cycle
  elementwise_alu #(
    .LR_SHIFT (LR_SHIFT)
  ) elementwise_alu_i (
    .op     (alu_op),
    .opnd_a (opnd_a),
    .opnd_b (opnd_b),
    .result (result)
  );

endmodule

//--- verification/vector_memory_model.sv
`timescale 1ns/1ps

module vector_memory_model (
  input  logic           clk,
  input  logic           rd_en,
  input  mem_pkg::addr_t rd_addr,
  output fpu_pkg::elem_t rd_data,
  input  logic           wr_en,
  input  mem_pkg::addr_t wr_addr,
  input  fpu_pkg::elem_t wr_data
);

  localparam int DEPTH = 1 << mem_pkg::ADDR_W;

  fpu_pkg::elem_t mem [DEPTH];

  // Every word starts with a value tied to its own address
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = {6'h2a, mem_pkg::addr_t'(i)};
    end
  end

  // Read data shows up one cycle after the request
  always @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] = wr_data;
    end
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

  task automatic preload(input mem_pkg::addr_t addr, input fpu_pkg::elem_t data);
    mem[addr] = data;
  endtask

  task automatic peek(input mem_pkg::addr_t addr, output fpu_pkg::elem_t data);
    data = mem[addr];
  endtask

endmodule

//--- verification/fpu_job_manager_tb.sv
`timescale 1ns/1ps

module fpu_job_manager_tb;

  localparam int LR_SHIFT    = 3;
  localparam int CLK_PERIOD  = 100;
  localparam int VEC_LEN     = 16;
  localparam int SRC_A       = 'h040;
  localparam int SRC_B       = 'h080;
  localparam int DST         = 'h100;
  localparam int DST_IGNORED = 'h200;
  localparam int DST_EMPTY   = 'h300;
  // Five full jobs and one empty job plus per-job overhead, reset and margin
  localparam int WATCHDOG_CYCLES = 5 * (3 * VEC_LEN + 1) + 1 + 6 * 4 + 5 + 20;

  logic           clk;
  logic           rst_l;
  logic           start;
  fpu_pkg::op_e   op;
  mem_pkg::addr_t src_a;
  mem_pkg::addr_t src_b;
  mem_pkg::addr_t dst;
  fpu_pkg::len_t  len;
  logic           busy;
  logic           done;
  logic [3:0]     job_count;
  logic           rd_en;
  mem_pkg::addr_t rd_addr;
  fpu_pkg::elem_t rd_data;
  logic           wr_en;
  mem_pkg::addr_t wr_addr;
  fpu_pkg::elem_t wr_data;

  integer         seed = 32'hacc;
  int             jobs_accepted = 0;
  fpu_pkg::elem_t a_vals [VEC_LEN];
  fpu_pkg::elem_t b_vals [VEC_LEN];

  fpu_job_manager #(
    .LR_SHIFT (LR_SHIFT)
  ) fpu_job_manager_i (
    .clk       (clk),
    .rst_l     (rst_l),
    .start     (start),
    .op        (op),
    .src_a     (src_a),
    .src_b     (src_b),
    .dst       (dst),
    .len       (len),
    .busy      (busy),
    .done      (done),
    .job_count (job_count),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data)
  );

  vector_memory_model vector_memory_model_i (
    .clk     (clk),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: done never came within %0d cycles", WATCHDOG_CYCLES);
    $display("Result: FAILED");
    $fatal(1, "watchdog expired");
  end

  task automatic compare_values(input string name, input int expected, input int actual);
    if (expected != actual) begin
      $display("mismatch %s expected %0d actual %0d", name, expected, actual);
      $display("Result: FAILED");
      $fatal(1, "value check failed");
    end
  endtask

  function automatic int clamp_elem(input int value);
    if (value > int'(fpu_pkg::ELEM_MAX)) begin
      return int'(fpu_pkg::ELEM_MAX);
    end
    if (value < int'(fpu_pkg::ELEM_MIN)) begin
      return int'(fpu_pkg::ELEM_MIN);
    end
    return value;
  endfunction

  function automatic int expected_elem(input fpu_pkg::op_e job_op, input int a, input int b);
    case (job_op)
      fpu_pkg::OP_RELU_FW:      return (a > 0) ? a : 0;
      fpu_pkg::OP_RELU_BW:      return (a > 0) ? b : 0;
      fpu_pkg::OP_PARAM_UPDATE: return clamp_elem(a - (b >>> LR_SHIFT));
      default:                  return clamp_elem(a - b);
    endcase
  endfunction

  // Same pattern the memory model starts with
  function automatic int fill_value(input int addr);
    return int'(fpu_pkg::elem_t'({6'h2a, mem_pkg::addr_t'(addr)}));
  endfunction

  task automatic fill_vectors();
    for (int i = 0; i < VEC_LEN; i++) begin
      a_vals[i] = fpu_pkg::elem_t'($random(seed));
      b_vals[i] = fpu_pkg::elem_t'($random(seed));
    end
    // Zero, negative and saturating corners
    a_vals[0] = '0;
    a_vals[1] = -16'sd1;
    a_vals[2] = fpu_pkg::ELEM_MAX;
    b_vals[2] = fpu_pkg::ELEM_MIN;
    a_vals[3] = fpu_pkg::ELEM_MIN;
    b_vals[3] = fpu_pkg::ELEM_MAX;
    a_vals[4] = 16'sd50;
    b_vals[4] = -16'sd100;
  endtask

  // Cycles are counted on falling edges from the start cycle as cycle 0
  task automatic run_job(input fpu_pkg::op_e job_op, input int dst_base, input int n,
                         input bit ignored_start, output int cycles, output int accesses);
    @(negedge clk);
    compare_values("busy before start", 0, int'(busy));
    start = 1'b1;
    op    = job_op;
    src_a = mem_pkg::addr_t'(SRC_A);
    src_b = mem_pkg::addr_t'(SRC_B);
    dst   = mem_pkg::addr_t'(dst_base);
    len   = fpu_pkg::len_t'(n);
    @(negedge clk);
    start    = 1'b0;
    cycles   = 1;
    accesses = 0;
    while (!done) begin
      compare_values("busy during job", 1, int'(busy));
      if (rd_en || wr_en) begin
        accesses++;
      end
      // Second request lands in READ_B and must be dropped
      start = ignored_start && (cycles == 2);
      if (start) begin
        op  = fpu_pkg::OP_MSE_BW;
        dst = mem_pkg::addr_t'(DST_IGNORED);
      end
      @(negedge clk);
      cycles++;
    end
    compare_values("busy in done cycle", 1, int'(busy));
    jobs_accepted++;
    @(negedge clk);
    compare_values("done pulse width", 0, int'(done));
    compare_values("busy after done", 0, int'(busy));
    compare_values("job_count", jobs_accepted % 16, int'(job_count));
  endtask

  task automatic check_job(input string name, input fpu_pkg::op_e job_op, input int dst_base,
                           input int n, input bit ignored_start);
    int             cycles;
    int             accesses;
    fpu_pkg::elem_t word;
    for (int i = 0; i < n; i++) begin
      vector_memory_model_i.preload(mem_pkg::addr_t'(SRC_A + i), a_vals[i]);
      vector_memory_model_i.preload(mem_pkg::addr_t'(SRC_B + i), b_vals[i]);
    end
    run_job(job_op, dst_base, n, ignored_start, cycles, accesses);
    compare_values($sformatf("%s done latency", name), 3 * n + 1, cycles);
    compare_values($sformatf("%s memory accesses", name), 3 * n, accesses);
    for (int i = 0; i < n; i++) begin
      vector_memory_model_i.peek(mem_pkg::addr_t'(dst_base + i), word);
      compare_values($sformatf("%s elem %0d", name, i),
                     expected_elem(job_op, int'(a_vals[i]), int'(b_vals[i])), int'(word));
    end
    vector_memory_model_i.peek(mem_pkg::addr_t'(dst_base - 1), word);
    compare_values($sformatf("%s word below dst", name), fill_value(dst_base - 1), int'(word));
    vector_memory_model_i.peek(mem_pkg::addr_t'(dst_base + n), word);
    compare_values($sformatf("%s word above dst", name), fill_value(dst_base + n), int'(word));
    if (ignored_start) begin
      for (int i = 0; i < VEC_LEN; i++) begin
        vector_memory_model_i.peek(mem_pkg::addr_t'(DST_IGNORED + i), word);
        compare_values($sformatf("%s ignored dst %0d", name, i),
                       fill_value(DST_IGNORED + i), int'(word));
      end
    end
  endtask

  task automatic reset_outputs();
    compare_values("reset busy", 0, int'(busy));
    compare_values("reset done", 0, int'(done));
    compare_values("reset rd_en", 0, int'(rd_en));
    compare_values("reset wr_en", 0, int'(wr_en));
    compare_values("reset job_count", 0, int'(job_count));
  endtask

  task automatic relu_both_ways();
    fill_vectors();
    check_job("relu_fw", fpu_pkg::OP_RELU_FW, DST, VEC_LEN, 1'b0);
    check_job("relu_bw", fpu_pkg::OP_RELU_BW, DST, VEC_LEN, 1'b0);
  endtask

  task automatic param_update();
    fill_vectors();
    check_job("param_update", fpu_pkg::OP_PARAM_UPDATE, DST, VEC_LEN, 1'b0);
  endtask

  task automatic mse_backward();
    fill_vectors();
    check_job("mse_bw", fpu_pkg::OP_MSE_BW, DST, VEC_LEN, 1'b0);
  endtask

  task automatic job_timing();
    fill_vectors();
    check_job("start_while_busy", fpu_pkg::OP_RELU_FW, DST, VEC_LEN, 1'b1);
    check_job("empty_job", fpu_pkg::OP_PARAM_UPDATE, DST_EMPTY, 0, 1'b0);
  endtask

  initial begin
    rst_l = 1'b0;
    start = 1'b0;
    op    = fpu_pkg::OP_RELU_FW;
    src_a = '0;
    src_b = '0;
    dst   = '0;
    len   = '0;
    repeat (5) @(negedge clk);
    reset_outputs();
    rst_l = 1'b1;
    relu_both_ways();
    param_update();
    mse_backward();
    job_timing();
    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- project.f
logic/fpu_pkg.sv
logic/mem_pkg.sv
logic/elementwise_alu.sv
logic/job_sequencer.sv
logic/fpu_job_manager.sv
verification/vector_memory_model.sv
verification/fpu_job_manager_tb.sv

//--- Makefile
# Verilator build for the FPU job manager

VERILATOR ?= verilator
FILELIST  ?= project.f
RTL_TOP   ?= fpu_job_manager
TB_TOP    ?= fpu_job_manager_tb
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# The run passes only when the pass line shows up in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
	  --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	  echo "$$out"; \
	  echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
